/* Bender.yml */
package:
  name: board_top

sources:
  - rtl/board_pkg.sv
  - rtl/i2c_adc_reader.sv
  - rtl/adc_display_format.sv
  - rtl/seg_scan.sv
  - rtl/key_debounce.sv
  - rtl/buzzer.sv
  - rtl/board_top.sv
  - target: test
    files:
      - testbench/board_top_assert.sv
      - testbench/board_top_tb.sv

/* board_top.f */
rtl/board_pkg.sv
rtl/i2c_adc_reader.sv
rtl/adc_display_format.sv
rtl/seg_scan.sv
rtl/key_debounce.sv
rtl/buzzer.sv
rtl/board_top.sv
testbench/board_top_assert.sv
testbench/board_top_tb.sv

/* rtl/adc_display_format.sv */
`timescale 1ns/1ps
// ==========================================================
// sample to display row
// channel letter on the left, decimal value on the right
// with leading zeros blanked
// ==========================================================
module adc_display_format import board_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  sample_t    sample,
	input  logic       sample_vld,
	output glyph_row_t glyphs
);

	glyph_t hund;
	glyph_t tens;
	glyph_t ones;
	glyph_t hund_g;
	glyph_t tens_g;

	always_comb begin
		hund   = glyph_t'(sample / 8'd100);
		tens   = glyph_t'((sample / 8'd10) % 8'd10);
		ones   = glyph_t'(sample % 8'd10);
		// leading zero suppression
		hund_g = (sample < 8'd100) ? GLYPH_BLANK : hund;
		tens_g = (sample < 8'd10) ? GLYPH_BLANK : tens;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			glyphs <= {GLYPH_A, {7{GLYPH_BLANK}}};
		end else if (sample_vld) begin
			glyphs <= {GLYPH_A, {4{GLYPH_BLANK}}, hund_g, tens_g, ones};
		end
	end

endmodule

/* rtl/board_pkg.sv */
// ==========================================================
// board package
// shared widths, glyph codes, I2C sequencer states and the
// fixed board timing constants
// ==========================================================
package board_pkg;

	// timing, in sys_clk cycles
	localparam int I2C_QUARTER     = 62;
	localparam int SCAN_CYCLES     = 256;
	localparam int DEBOUNCE_CYCLES = 2000;
	localparam int BEEP_CYCLES     = 20000;
	localparam int TONE_HALF       = 100;

	typedef logic [7:0]  sample_t;
	typedef logic [3:0]  glyph_t;
	typedef logic [31:0] glyph_row_t;
	// dp g f e d c b a, active low
	typedef logic [7:0]  seg_t;
	typedef logic [3:0]  key_t;

	typedef logic [$clog2(I2C_QUARTER)-1:0]     quarter_cnt_t;
	typedef logic [$clog2(SCAN_CYCLES)-1:0]     scan_cnt_t;
	typedef logic [$clog2(DEBOUNCE_CYCLES)-1:0] debounce_cnt_t;
	typedef logic [$clog2(BEEP_CYCLES+1)-1:0]   beep_cnt_t;
	typedef logic [$clog2(TONE_HALF)-1:0]       tone_cnt_t;

	localparam glyph_t GLYPH_BLANK = 4'd10;
	localparam glyph_t GLYPH_A     = 4'd11;

	// PCF8591 style converter, A2..A0 tied low
	localparam logic [6:0] ADC_DEV_ADDR  = 7'h48;
	// input channel 0, single ended, no auto increment
	localparam logic [7:0] ADC_CTRL_BYTE = 8'h00;

	typedef enum logic [3:0] {
		IDLE, START, ADDR_W, CTRL, RESTART, ADDR_R, READ, NACK, STOP
	} i2c_state_t;

endpackage

/* rtl/board_top.sv */
`timescale 1ns/1ps
// ==========================================================
// board top
// ADC readout on the segment display plus keys, LEDs, buzzer
// ==========================================================
module board_top import board_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  key_t       key_in,
	output logic       bepeer,
	output logic [7:0] led,
	output seg_t       seg_number,
	output logic [7:0] seg_choice,
	output logic       scl,
	inout  wire        sda
);

	sample_t    sample;
	logic       sample_vld;
	glyph_row_t glyphs;
	logic [3:0] key_press;

	i2c_adc_reader u_adc (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.sample     (sample),
		.sample_vld (sample_vld),
		.scl        (scl),
		.sda        (sda)
	);

	adc_display_format u_fmt (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.sample     (sample),
		.sample_vld (sample_vld),
		.glyphs     (glyphs)
	);

	seg_scan u_scan (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.glyphs     (glyphs),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

	key_debounce u_keys (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.key_in     (key_in),
		.key_press  (key_press),
		.led        (led)
	);

	buzzer u_buzzer (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.key_press  (key_press),
		.bepeer     (bepeer)
	);

endmodule

/* rtl/buzzer.sv */
`timescale 1ns/1ps
// ==========================================================
// buzzer
// fixed-length square wave beep, retriggered by key presses
// ==========================================================
module buzzer import board_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [3:0] key_press,
	output logic       bepeer
);

	beep_cnt_t dur;
	tone_cnt_t tone_cnt;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			dur      <= '0;
			tone_cnt <= '0;
			bepeer   <= 1'b0;
		end else if (|key_press) begin
			dur      <= beep_cnt_t'(BEEP_CYCLES);
			tone_cnt <= '0;
		end else if (dur > beep_cnt_t'(1)) begin
			dur <= dur - 1'b1;
			if (tone_cnt == tone_cnt_t'(TONE_HALF - 1)) begin
				tone_cnt <= '0;
				bepeer   <= ~bepeer;
			end else begin
				tone_cnt <= tone_cnt + 1'b1;
			end
		end else begin
			// beep over, output rests low
			dur      <= '0;
			tone_cnt <= '0;
			bepeer   <= 1'b0;
		end
	end

endmodule

/* rtl/i2c_adc_reader.sv */
`timescale 1ns/1ps
// ==========================================================
// I2C converter reader
// loops write-control / repeated-start / read-one-byte
// transactions and strobes each received sample
// ==========================================================
module i2c_adc_reader import board_pkg::*; (
	input  logic    sys_clk,
	input  logic    sys_rst_n,
	output sample_t sample,
	output logic    sample_vld,
	output logic    scl,
	inout  wire     sda
);

	quarter_cnt_t qcnt;
	logic         tick;
	logic [1:0]   phase;
	logic [3:0]   bit_cnt;
	i2c_state_t   state;
	i2c_state_t   send_next;
	logic         send_st;
	logic [7:0]   tx_byte;
	logic         sda_rel;
	logic [1:0]   sda_sync;
	logic         ack_nok;
	logic         rx_edge;
	sample_t      rx_shift;
	logic         scl_nxt;
	logic         sda_nxt;

	// open drain, released means pulled high
	assign sda     = sda_rel ? 1'bz : 1'b0;
	assign tick    = (qcnt == quarter_cnt_t'(I2C_QUARTER - 1));
	assign send_st = (state == ADDR_W) || (state == CTRL) || (state == ADDR_R);
	// phase 1 end is the middle of the SCL high time
	assign rx_edge = tick && (phase == 2'd1) && (state == READ);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			qcnt  <= '0;
			phase <= 2'd0;
		end else if (tick) begin
			qcnt  <= '0;
			phase <= phase + 2'd1;
		end else begin
			qcnt  <= qcnt + 1'b1;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			sda_sync <= 2'b11;
		end else begin
			sda_sync <= {sda_sync[0], sda};
		end
	end

	always_comb begin
		case (state)
			ADDR_W: begin
				tx_byte   = {ADC_DEV_ADDR, 1'b0};
				send_next = CTRL;
			end
			CTRL: begin
				tx_byte   = ADC_CTRL_BYTE;
				send_next = RESTART;
			end
			default: begin
				tx_byte   = {ADC_DEV_ADDR, 1'b1};
				send_next = READ;
			end
		endcase
	end

	// sequencer steps once per bit, at the end of phase 3
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= IDLE;
			bit_cnt <= 4'd0;
			ack_nok <= 1'b0;
		end else if (tick) begin
			if (phase == 2'd1 && send_st && bit_cnt == 4'd8)
				ack_nok <= sda_sync[1];
			if (phase == 2'd3) begin
				case (state)
					IDLE:    state <= START;
					START:   state <= ADDR_W;
					RESTART: state <= ADDR_R;
					ADDR_W, CTRL, ADDR_R: begin
						if (bit_cnt != 4'd8) begin
							bit_cnt <= bit_cnt + 4'd1;
						end else begin
							bit_cnt <= 4'd0;
							// no ack, close the bus and start over
							state   <= ack_nok ? STOP : send_next;
						end
					end
					READ: begin
						if (bit_cnt != 4'd7) begin
							bit_cnt <= bit_cnt + 4'd1;
						end else begin
							bit_cnt <= 4'd0;
							state   <= NACK;
						end
					end
					NACK:    state <= STOP;
					STOP:    state <= START;
					default: state <= IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rx_edge)
			rx_shift <= {rx_shift[6:0], sda_sync[1]};
		if (rx_edge && bit_cnt == 4'd7)
			sample <= {rx_shift[6:0], sda_sync[1]};
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			sample_vld <= 1'b0;
		end else begin
			sample_vld <= rx_edge && (bit_cnt == 4'd7);
		end
	end

	// bus levels per state and phase; SCL high in phases 1 and 2 for data bits
	always_comb begin
		scl_nxt = (phase == 2'd1) || (phase == 2'd2);
		sda_nxt = 1'b1;
		case (state)
			IDLE: scl_nxt = 1'b1;
			START, RESTART: begin
				scl_nxt = (phase != 2'd3) && !(state == RESTART && phase == 2'd0);
				sda_nxt = (phase[1] == 1'b0);
			end
			ADDR_W, CTRL, ADDR_R: sda_nxt = bit_cnt[3] | tx_byte[3'd7 - bit_cnt[2:0]];
			STOP: begin
				scl_nxt = (phase != 2'd0);
				sda_nxt = phase[1];
			end
			// READ and NACK leave sda released
			default: sda_nxt = 1'b1;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scl     <= 1'b1;
			sda_rel <= 1'b1;
		end else begin
			scl     <= scl_nxt;
			sda_rel <= sda_nxt;
		end
	end

endmodule

/* rtl/key_debounce.sv */
`timescale 1ns/1ps
// ==========================================================
// key debouncer
// press pulses per key, LED toggles and held-key display
// ==========================================================
module key_debounce import board_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  key_t       key_in,
	output logic [3:0] key_press,
	output logic [7:0] led
);

	key_t          sync1;
	key_t          sync2;
	key_t          stable;
	debounce_cnt_t cnt [4];
	logic [3:0]    led_tgl;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			sync1 <= '1;
			sync2 <= '1;
		end else begin
			sync1 <= key_in;
			sync2 <= sync1;
		end
	end

	// counter runs only while the input disagrees with the debounced level
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			stable    <= '1;
			key_press <= 4'd0;
			led_tgl   <= 4'd0;
			for (int i = 0; i < 4; i++)
				cnt[i] <= '0;
		end else begin
			key_press <= 4'd0;
			for (int i = 0; i < 4; i++) begin
				if (sync2[i] == stable[i]) begin
					cnt[i] <= '0;
				end else if (cnt[i] == debounce_cnt_t'(DEBOUNCE_CYCLES - 1)) begin
					cnt[i]    <= '0;
					stable[i] <= sync2[i];
					// keys are active low
					if (!sync2[i]) begin
						key_press[i] <= 1'b1;
						led_tgl[i]   <= ~led_tgl[i];
					end
				end else begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

	assign led = {~stable, led_tgl};

endmodule

/* rtl/seg_scan.sv */
`timescale 1ns/1ps
// ==========================================================
// seven segment scanner
// cycles through eight digits, decodes the lit glyph
// ==========================================================
module seg_scan import board_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  glyph_row_t glyphs,
	output seg_t       seg_number,
	output logic [7:0] seg_choice
);

	scan_cnt_t  dwell;
	logic [2:0] digit;
	glyph_t     cur;

	// active low, dp kept off
	function automatic seg_t glyph_to_seg(glyph_t g);
		case (g)
			4'd0:    return 8'hc0;
			4'd1:    return 8'hf9;
			4'd2:    return 8'ha4;
			4'd3:    return 8'hb0;
			4'd4:    return 8'h99;
			4'd5:    return 8'h92;
			4'd6:    return 8'h82;
			4'd7:    return 8'hf8;
			4'd8:    return 8'h80;
			4'd9:    return 8'h90;
			GLYPH_A: return 8'h88;
			default: return 8'hff;
		endcase
	endfunction

	assign cur = glyphs[{digit, 2'b00} +: 4];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			dwell <= '0;
			digit <= 3'd0;
		end else if (dwell == scan_cnt_t'(SCAN_CYCLES - 1)) begin
			dwell <= '0;
			digit <= digit + 3'd1;
		end else begin
			dwell <= dwell + 1'b1;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			seg_number <= 8'hff;
			seg_choice <= 8'hfe;
		end else begin
			seg_number <= glyph_to_seg(cur);
			seg_choice <= ~(8'd1 << digit);
		end
	end

endmodule

/* testbench/board_top_assert.sv */
`timescale 1ns/1ps
// ============================================================
// board top assertions
// digit select, sample strobe, I2C bus and buzzer rules
// ============================================================
module board_top_assert import board_pkg::*; (
	input logic       sys_clk,
	input logic       sys_rst_n,
	input logic [7:0] seg_choice,
	input logic       sample_vld,
	input logic       scl,
	input logic       sda,
	input i2c_state_t i2c_state,
	input beep_cnt_t  beep_dur,
	input logic       bepeer
);

	int fail_cnt = 0;

	one_digit: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$onehot(~seg_choice))
	else begin
		$error("digit select is not one-hot");
		fail_cnt++;
	end

	vld_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		sample_vld |=> !sample_vld)
	else begin
		$error("sample strobe longer than one cycle");
		fail_cnt++;
	end

	// data moves only while scl is low, START and STOP aside
	sda_stable: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(scl && $past(scl) && !(i2c_state inside {START, RESTART, STOP})) |-> $stable(sda))
	else begin
		$error("sda changed while scl high");
		fail_cnt++;
	end

	beep_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(beep_dur == '0) |-> !bepeer)
	else begin
		$error("buzzer active with beep counter at zero");
		fail_cnt++;
	end

endmodule

bind board_top board_top_assert u_assert (
	.sys_clk    (sys_clk),
	.sys_rst_n  (sys_rst_n),
	.seg_choice (seg_choice),
	.sample_vld (sample_vld),
	.scl        (scl),
	.sda        (sda),
	.i2c_state  (u_adc.state),
	.beep_dur   (u_buzzer.dur),
	.bepeer     (bepeer)
);

/* testbench/board_top_tb.sv */
`timescale 1ns/1ps
// ============================================================
// board top testbench
// I2C converter slave model, key stimulus, display and buzzer
// checks against reference values
// ============================================================
module board_top_tb import board_pkg::*; ();

	localparam int XFER_CYCLES = 40 * 4 * I2C_QUARTER;

	logic       sys_clk;
	logic       sys_rst_n;
	key_t       key_in;
	logic       bepeer;
	logic [7:0] led;
	seg_t       seg_number;
	logic [7:0] seg_choice;
	logic       scl;
	wire        sda;

	// converter slave model state
	logic       slave_low;
	logic       nack_addr;
	sample_t    slave_byte;
	logic [3:0] sl_bit;
	logic [7:0] sl_shift;
	logic [7:0] sl_tx;
	logic       sl_busy;
	logic       sl_first;
	logic       sl_read;
	int         reads_done;
	int         addr_nacked;
	int         errors;
	logic [7:0] led_exp;

	board_top dut (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.key_in     (key_in),
		.bepeer     (bepeer),
		.led        (led),
		.seg_number (seg_number),
		.seg_choice (seg_choice),
		.scl        (scl),
		.sda        (sda)
	);

	pullup (sda);
	assign sda = slave_low ? 1'b0 : 1'bz;

	always #4 sys_clk = ~sys_clk;

	// start or repeated start
	always @(negedge sda) begin
		if (scl === 1'b1) begin
			sl_busy  = 1'b1;
			sl_first = 1'b1;
			sl_read  = 1'b0;
			sl_bit   = 4'd0;
		end
	end

	always @(posedge sda) begin
		if (scl === 1'b1)
			sl_busy = 1'b0;
	end

	always @(posedge scl) begin
		if (sl_busy) begin
			if (!sl_read && sl_bit < 4'd8)
				sl_shift = {sl_shift[6:0], sda};
			sl_bit = sl_bit + 4'd1;
		end
	end

	// slave drives only while scl is low
	always @(negedge scl) begin
		if (sl_busy) begin
			if (sl_bit == 4'd8 && !sl_read) begin
				if (sl_first && (sl_shift[7:1] != ADC_DEV_ADDR || nack_addr)) begin
					addr_nacked++;
					sl_busy = 1'b0;
				end else begin
					slave_low = 1'b1;
				end
			end else if (sl_bit == 4'd9) begin
				sl_bit    = 4'd0;
				slave_low = 1'b0;
				if (sl_read) begin
					reads_done++;
					sl_busy = 1'b0;
				end else if (sl_first && sl_shift[0]) begin
					sl_read   = 1'b1;
					sl_tx     = slave_byte;
					slave_low = !sl_tx[7];
				end
				sl_first = 1'b0;
			end else if (sl_read) begin
				// drive the next data bit or release for the master NACK
				slave_low = (sl_bit < 4'd8) ? !sl_tx[4'd7 - sl_bit] : 1'b0;
			end
		end
	end

	function automatic glyph_row_t expected_row(input sample_t v);
		glyph_row_t row;
		string      dec;
		row = {GLYPH_A, {7{GLYPH_BLANK}}};
		dec = $sformatf("%0d", v);
		// the last decimal character lands in digit 0
		for (int i = 0; i < dec.len(); i++)
			row[4*i +: 4] = glyph_t'(dec[dec.len() - 1 - i] - 8'h30);
		return row;
	endfunction

	// lit segments as g f e d c b a and inverted for the active low pins
	function automatic seg_t expected_seg(input glyph_t g);
		logic [6:0] lit;
		case (g)
			4'd0:    lit = 7'h3f;
			4'd1:    lit = 7'h06;
			4'd2:    lit = 7'h5b;
			4'd3:    lit = 7'h4f;
			4'd4:    lit = 7'h66;
			4'd5:    lit = 7'h6d;
			4'd6:    lit = 7'h7d;
			4'd7:    lit = 7'h07;
			4'd8:    lit = 7'h7f;
			4'd9:    lit = 7'h6f;
			GLYPH_A: lit = 7'h77;
			default: lit = 7'h00;
		endcase
		return {1'b1, ~lit};
	endfunction

	task automatic timed_out(input string what);
		$display("timeout while waiting for %s", what);
		$display("tests failed");
		$finish;
	endtask

	task automatic check_eq(input string name, input int exp, input int act);
		if (exp !== act) begin
			$display("[ERROR] %s expected %0h actual %0h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_display(input string name, input glyph_row_t row);
		seg_t       got [8];
		logic [7:0] seen;
		int         n;
		seen = 8'd0;
		n    = 0;
		while (seen != 8'hff) begin
			if (n == 3 * 8 * SCAN_CYCLES)
				timed_out({name, " display scan"});
			@(negedge sys_clk);
			n++;
			for (int d = 0; d < 8; d++) begin
				if (!seg_choice[d]) begin
					got[d]  = seg_number;
					seen[d] = 1'b1;
				end
			end
		end
		for (int d = 0; d < 8; d++)
			check_eq($sformatf("%s digit %0d", name, d), expected_seg(row[4*d +: 4]), got[d]);
	endtask

	task automatic wait_reads(input int count);
		int target;
		int n;
		target = reads_done + count;
		n      = 0;
		while (reads_done < target) begin
			if (n == (count + 1) * XFER_CYCLES)
				timed_out("a converter read");
			@(negedge sys_clk);
			n++;
		end
	endtask

	task automatic wait_nacks(input int count);
		int target;
		int n;
		target = addr_nacked + count;
		n      = 0;
		while (addr_nacked < target) begin
			if (n == (count + 1) * XFER_CYCLES)
				timed_out("an address retry");
			@(negedge sys_clk);
			n++;
		end
	endtask

	task automatic wait_led(input int b, input logic value);
		int n;
		n = 0;
		while (led[b] !== value) begin
			if (n == 2 * DEBOUNCE_CYCLES)
				timed_out($sformatf("led %0d", b));
			@(negedge sys_clk);
			n++;
		end
	endtask

	task automatic drive_key(input int k, input logic level, input int hold);
		@(posedge sys_clk);
		key_in[k] <= level;
		repeat (hold) @(posedge sys_clk);
	endtask

	// three contact bounces before the line settles at level
	task automatic bounce_key(input int k, input logic level);
		for (int i = 0; i < 3; i++) begin
			drive_key(k, level, 10 + $urandom % 60);
			drive_key(k, !level, 5 + $urandom % 30);
		end
		drive_key(k, level, 0);
	endtask

	task automatic count_toggles(input int cycles, output int toggles);
		logic prev;
		prev    = bepeer;
		toggles = 0;
		repeat (cycles) begin
			@(negedge sys_clk);
			if (bepeer !== prev)
				toggles++;
			prev = bepeer;
		end
	endtask

	initial begin
		sample_t corner [6];
		sample_t v;
		sample_t last;
		int      toggles;
		corner      = '{8'd0, 8'd9, 8'd10, 8'd99, 8'd100, 8'd255};
		sys_clk     = 1'b0;
		sys_rst_n   = 1'b0;
		key_in      = '1;
		slave_low   = 1'b0;
		nack_addr   = 1'b0;
		slave_byte  = 8'd0;
		sl_busy     = 1'b0;
		sl_first    = 1'b0;
		sl_read     = 1'b0;
		sl_bit      = 4'd0;
		reads_done  = 0;
		addr_nacked = 0;
		errors      = 0;
		led_exp     = 8'd0;
		last        = 8'd0;
		void'($urandom(23));
		repeat (16) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		@(negedge sys_clk);

		check_eq("reset led", 0, led);
		check_eq("reset buzzer", 0, bepeer);
		check_display("reset display", {GLYPH_A, {7{GLYPH_BLANK}}});

		for (int i = 0; i < 10; i++) begin
			v          = (i < 6) ? corner[i] : sample_t'($urandom);
			slave_byte = v;
			wait_reads(2);
			check_display($sformatf("sample %0d", v), expected_row(v));
			last = v;
		end

		// display holds while the address is not acknowledged
		nack_addr = 1'b1;
		wait_nacks(2);
		check_display("nack hold", expected_row(last));
		slave_byte = last ^ 8'h5a;
		wait_nacks(3);
		check_display("nack new byte", expected_row(last));
		nack_addr = 1'b0;
		wait_reads(2);
		check_display("ack again", expected_row(slave_byte));

		bounce_key(1, 1'b0);
		wait_led(1, 1'b1);
		led_exp = 8'b0010_0010;
		repeat (2 * DEBOUNCE_CYCLES) @(negedge sys_clk);
		check_eq("key 1 press", led_exp, led);
		bounce_key(1, 1'b1);
		wait_led(5, 1'b0);
		led_exp = 8'b0000_0010;
		repeat (2 * DEBOUNCE_CYCLES) @(negedge sys_clk);
		check_eq("key 1 release", led_exp, led);
		drive_key(2, 1'b0, DEBOUNCE_CYCLES / 2);
		drive_key(2, 1'b1, 2 * DEBOUNCE_CYCLES);
		check_eq("key 2 glitch", led_exp, led);

		drive_key(0, 1'b0, 0);
		wait_led(0, 1'b1);
		drive_key(0, 1'b1, 0);
		count_toggles(BEEP_CYCLES + 2 * TONE_HALF, toggles);
		if (toggles < BEEP_CYCLES / TONE_HALF - 2 || toggles > BEEP_CYCLES / TONE_HALF + 2) begin
			$display("[ERROR] beep toggles expected %0d actual %0d",
				BEEP_CYCLES / TONE_HALF, toggles);
			errors++;
		end
		check_eq("beep end", 0, bepeer);
		count_toggles(4 * TONE_HALF, toggles);
		check_eq("beep quiet", 0, toggles);
		led_exp = 8'b0000_0011;
		check_eq("key 0 press", led_exp, led);

		$display("checks done, %0d errors, %0d assertion failures",
			errors, dut.u_assert.fail_cnt);
		if (errors == 0 && dut.u_assert.fail_cnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
